// ==== cpuCore.f ====
rtl/cpuPkg.sv
rtl/cpuFetch.sv
rtl/cpuDecode.sv
rtl/cpuExecute.sv
rtl/cpuMemory.sv
rtl/hazardUnit.sv
rtl/cpu.sv
testbench/cpuChecks_sva.sv
testbench/cpuTb.sv

// ==== Makefile ====
TOP := cpuTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build folder"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f cpuCore.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== testbench/cpuTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuTb;

   localparam int numPrograms = 6;
   localparam int bodyLen     = 40;     // Random words between preamble and HLT
   localparam int runLimit    = 2000;   // Cycles allowed until hlt

   logic             clk;
   logic             reset;
   logic             imemWrite;
   cpuPkg::word_t    imemAddr;
   cpuPkg::word_t    imemData;
   cpuPkg::word_t    pc;
   logic             hlt;
   logic             retire;
   cpuPkg::regAddr_t retireAddr;
   cpuPkg::word_t    retireData;

   cpuPkg::word_t    prog [$];
   cpuPkg::regAddr_t expAddr [$];    // Model's register writes, in order
   cpuPkg::word_t    expData [$];
   cpuPkg::word_t    expPc;
   int               expCount;
   int               seenCount;
   int               errorCount;
   integer           seed;

   cpu #(.imemAddrBits(8), .dmemAddrBits(8)) dut_i (
      .clk(clk), .reset(reset), .imemWrite(imemWrite), .imemAddr(imemAddr),
      .imemData(imemData), .pc(pc), .hlt(hlt), .retire(retire),
      .retireAddr(retireAddr), .retireData(retireData)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic abortRun(input string msg);
      errorCount++;
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at first failure");
   endtask

   task automatic reportError(input string msg);
      abortRun($sformatf("[ERROR] %0t: %s", $time, msg));
   endtask

   task automatic checkRetire(input cpuPkg::regAddr_t addr, input cpuPkg::word_t data);
      cpuPkg::regAddr_t wantAddr;
      cpuPkg::word_t    wantData;
      if (expAddr.size() == 0) begin
         abortRun("A register write retired after the model's last write");
      end else begin
         wantAddr = expAddr.pop_front();
         wantData = expData.pop_front();
         seenCount++;
         if (addr !== wantAddr || data !== wantData)
            reportError($sformatf("write %0d retired r%0d = %h, model has r%0d = %h",
                                  seenCount, addr, data, wantAddr, wantData));
      end
   endtask

   task automatic checkPc(input cpuPkg::word_t got);
      if (got !== expPc)
         reportError($sformatf("pc after halt is %h, model has %h", got, expPc));
   endtask

   task automatic checkCount(input int got);
      if (got != expCount)
         reportError($sformatf("%0d writes retired, model has %0d", got, expCount));
   endtask

   // Preamble, random body, then HLT
   task automatic makeProgram();
      int               kind;
      int               off;
      int               room;
      cpuPkg::regAddr_t rd;
      prog.delete();
      for (int k = 0; k < 8; k++)
         prog.push_back({cpuPkg::OP_SW, 4'd0, 4'd7, 4'(k)});   // r7 and r0 are zero here
      for (int i = 0; i < bodyLen; i++) begin
         kind = $unsigned($random(seed)) % 16;
         rd   = 4'($unsigned($random(seed)) % 7);   // r7 kept as the data base
         if (kind < 6 || kind == 15)
            prog.push_back({4'($unsigned($random(seed)) % 6), rd,
                            4'($random(seed) & 7), 4'($random(seed))});
         else if (kind < 8)
            prog.push_back({cpuPkg::OP_LDI, rd, 8'($random(seed))});
         else if (kind == 8)
            prog.push_back({cpuPkg::OP_LDI, 4'd7, 8'($unsigned($random(seed)) % 5)});
         else if (kind < 11)
            prog.push_back({cpuPkg::OP_LW, rd, 4'd7, 4'($random(seed) & 3)});
         else if (kind == 11)
            prog.push_back({cpuPkg::OP_SW, 4'($random(seed) & 7), 4'd7, 4'($random(seed) & 3)});
         else if (kind < 14) begin
            room = 8 + bodyLen - prog.size() - 1;     // Target stays at or before HLT
            off  = $unsigned($random(seed)) % 4;
            if (off > room)
               off = room;
            prog.push_back({cpuPkg::OP_B, 3'($random(seed) & 3), 9'(off)});
         end else
            prog.push_back({4'(10 + $unsigned($random(seed)) % 5), 12'($random(seed))});
      end
      prog.push_back({cpuPkg::OP_HLT, 12'd0});
   endtask

   // Instruction-set interpreter, one instruction per step
   task automatic runModel();
      cpuPkg::word_t regs [16];
      cpuPkg::word_t mem [256];
      cpuPkg::word_t ins;
      cpuPkg::word_t a;
      cpuPkg::word_t b;
      cpuPkg::word_t res;
      cpuPkg::word_t ea;
      logic          zf;
      logic          nf;
      logic          taken;
      int            at;
      int            steps;
      for (int i = 0; i < 16; i++)
         regs[i] = '0;
      for (int i = 0; i < 256; i++)
         mem[i] = '0;
      zf    = 1'b0;
      nf    = 1'b0;
      at    = 0;
      steps = 0;
      expAddr.delete();
      expData.delete();
      while (prog[at][15:12] != cpuPkg::OP_HLT && steps < 1000) begin
         ins = prog[at];
         a   = regs[ins[7:4]];
         b   = regs[ins[3:0]];
         ea  = a + {{12{ins[3]}}, ins[3:0]};   // LW and SW address
         res = '0;
         case (ins[15:12])
            cpuPkg::OP_ADD: res = a + b;
            cpuPkg::OP_SUB: res = a - b;
            cpuPkg::OP_AND: res = a & b;
            cpuPkg::OP_XOR: res = a ^ b;
            cpuPkg::OP_SLL: res = a << ins[3:0];
            cpuPkg::OP_SRL: res = a >> ins[3:0];
            cpuPkg::OP_LDI: res = {{8{ins[7]}}, ins[7:0]};
            cpuPkg::OP_LW:  res = mem[ea[7:0]];
            default:        res = '0;
         endcase
         if (ins[15:12] <= cpuPkg::OP_SRL) begin
            zf = res == '0;
            nf = res[15];
         end
         if (ins[15:12] <= cpuPkg::OP_LW) begin   // Opcodes 0 to 7 write rd
            regs[ins[11:8]] = res;
            expAddr.push_back(ins[11:8]);
            expData.push_back(res);
         end
         if (ins[15:12] == cpuPkg::OP_SW)
            mem[ea[7:0]] = regs[ins[11:8]];
         taken = 1'b0;
         if (ins[15:12] == cpuPkg::OP_B)
            case (ins[11:9])
               3'd0:    taken = !zf;
               3'd1:    taken = zf;
               3'd2:    taken = nf;
               3'd3:    taken = 1'b1;
               default: taken = 1'b0;
            endcase
         at = taken ? at + 1 + $signed(ins[8:0]) : at + 1;
         steps++;
      end
      if (steps >= 1000)
         abortRun("Model ran 1000 steps without reaching HLT");
      expPc    = cpuPkg::word_t'(at + 1);
      expCount = expAddr.size();
   endtask

   // Program goes in under reset, then five more reset cycles
   task automatic loadAndReset();
      @(posedge clk);
      reset <= 1'b1;
      for (int i = 0; i < prog.size(); i++) begin
         imemWrite <= 1'b1;
         imemAddr  <= 16'(i);
         imemData  <= prog[i];
         @(posedge clk);
      end
      imemWrite <= 1'b0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
   endtask

   task automatic runAndCheck(input int progNum);
      int cycles;
      cycles    = 0;
      seenCount = 0;
      while (!hlt && cycles < runLimit) begin
         @(negedge clk);                       // Outputs settled mid-cycle
         if (retire)
            checkRetire(retireAddr, retireData);
         cycles++;
      end
      if (!hlt) begin
         abortRun($sformatf("Timeout: hlt did not rise within %0d cycles in program %0d",
                            runLimit, progNum));
      end else begin
         checkPc(pc);
         checkCount(seenCount);
      end
   endtask

   initial begin
      seed       = 23;
      errorCount = 0;
      reset      = 1'b1;
      imemWrite  = 1'b0;
      imemAddr   = '0;
      imemData   = '0;
      for (int p = 0; p < numPrograms; p++) begin
         makeProgram();
         runModel();
         loadAndReset();
         runAndCheck(p);
         $display("Program %0d: %0d writes retired, pc %h", p, seenCount, pc);
      end
      if (errorCount == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/cpuChecks_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuChecks_sva (
   input logic          clk,
   input logic          reset,
   input logic          retire,
   input logic          hlt,
   input cpuPkg::word_t pc
);

   // Pipeline comes out of reset holding bubbles only
   noRetireInReset: assert property (@(posedge clk) reset |=> !retire)
      else $error("retire strobe seen while reset was applied");

   // Halt latch clears only through reset
   hltHolds: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
      else $error("hlt dropped without reset");

   pcFrozen: assert property (@(posedge clk) disable iff (reset) hlt |=> $stable(pc))
      else $error("pc moved after hlt");

   // Everything younger than HLT was squashed
   noRetireAfterHlt: assert property (@(posedge clk) disable iff (reset) hlt |-> !retire)
      else $error("register write retired after hlt");

endmodule

bind cpu cpuChecks_sva checks_i (
   .clk(clk), .reset(reset), .retire(retire), .hlt(hlt), .pc(pc)
);

`default_nettype wire

// ==== rtl/cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu #(
   parameter int imemAddrBits = 8,
   parameter int dmemAddrBits = 8
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             imemWrite,
   input  cpuPkg::word_t    imemAddr,
   input  cpuPkg::word_t    imemData,
   output cpuPkg::word_t    pc,
   output logic             hlt,
   output logic             retire,       // Register write at writeback
   output cpuPkg::regAddr_t retireAddr,
   output cpuPkg::word_t    retireData
);

   cpuPkg::word_t    instrId, pcId, branchTarget;
   logic             stall, flush, halting, branchTaken;
   cpuPkg::regAddr_t srcA, srcB, srcStore;
   logic             usesA, usesB, usesStore;
   cpuPkg::opcode_t  exAluOp;
   cpuPkg::word_t    exImm, exDataA, exDataB, exTarget;
   cpuPkg::regAddr_t exRd, exRs, exRt, exStoreReg;
   logic             exImmSel, exMemRead, exMemWrite, exRegWrite, exIsBranch, exIsHalt;
   cpuPkg::cond_t    exCond;
   cpuPkg::fwdSel_t  fwdA, fwdB, fwdStore;
   cpuPkg::word_t    memAluOut, memStoreData;
   cpuPkg::regAddr_t memRd;
   logic             memRead, memWrite, memRegWrite, memIsHalt;

   cpuFetch #(.imemAddrBits(imemAddrBits)) fetch_i (
      .clk, .reset, .imemWrite, .imemAddr, .imemData,
      .stall, .flush, .halting, .branchTaken, .branchTarget,
      .pc, .instrId, .pcId
   );

   cpuDecode decode_i (
      .clk, .reset, .instrId, .pcId, .stall, .flush,
      .wbWrite(retire), .wbAddr(retireAddr), .wbData(retireData),
      .halting, .srcA, .srcB, .srcStore, .usesA, .usesB, .usesStore,
      .exAluOp, .exImmSel, .exImm, .exDataA, .exDataB,
      .exRd, .exRs, .exRt, .exStoreReg,
      .exMemRead, .exMemWrite, .exRegWrite, .exIsBranch, .exCond, .exTarget, .exIsHalt
   );

   cpuExecute execute_i (
      .clk, .reset, .exAluOp, .exImmSel, .exImm, .exDataA, .exDataB, .exRd,
      .exMemRead, .exMemWrite, .exRegWrite, .exIsBranch, .exCond, .exTarget, .exIsHalt,
      .fwdA, .fwdB, .fwdStore, .memAluOut(memAluOut), .wbData(retireData),
      .branchTaken, .branchTarget, .flush,
      .memAluOutQ(memAluOut), .memStoreData, .memRd,
      .memRead, .memWrite, .memRegWrite, .memIsHalt
   );

   cpuMemory #(.dmemAddrBits(dmemAddrBits)) memory_i (
      .clk, .reset, .aluOut(memAluOut), .storeData(memStoreData), .rd(memRd),
      .memRead, .memWrite, .regWrite(memRegWrite), .isHalt(memIsHalt),
      .wbWrite(retire), .wbAddr(retireAddr), .wbData(retireData), .hlt
   );

   // Stall and forwarding selects
   hazardUnit hazard_i (
      .usesA, .usesB, .usesStore, .srcA, .srcB, .srcStore,
      .exRd, .exMemRead, .exRs, .exRt, .exStoreReg,
      .memRd, .memRegWrite, .memRead,
      .wbAddr(retireAddr), .wbWrite(retire),
      .stall, .fwdA, .fwdB, .fwdStore
   );

endmodule

`default_nettype wire

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
   input  logic             usesA,
   input  logic             usesB,
   input  logic             usesStore,
   input  cpuPkg::regAddr_t srcA,         // Sources of the word in IF/ID
   input  cpuPkg::regAddr_t srcB,
   input  cpuPkg::regAddr_t srcStore,
   input  cpuPkg::regAddr_t exRd,
   input  logic             exMemRead,
   input  cpuPkg::regAddr_t exRs,         // Sources of the word in ID/EX
   input  cpuPkg::regAddr_t exRt,
   input  cpuPkg::regAddr_t exStoreReg,
   input  cpuPkg::regAddr_t memRd,
   input  logic             memRegWrite,
   input  logic             memRead,
   input  cpuPkg::regAddr_t wbAddr,
   input  logic             wbWrite,
   output logic             stall,
   output cpuPkg::fwdSel_t  fwdA,
   output cpuPkg::fwdSel_t  fwdB,
   output cpuPkg::fwdSel_t  fwdStore
);

   logic memFwdOk;   // EX/MEM holds a finished ALU result

   function automatic cpuPkg::fwdSel_t pickFwd(
      input cpuPkg::regAddr_t src,
      input cpuPkg::regAddr_t memDst,
      input logic             memOk,
      input cpuPkg::regAddr_t wbDst,
      input logic             wbOk
   );
      if (memOk && memDst == src)
         return cpuPkg::FWD_MEM;   // Youngest writer first
      if (wbOk && wbDst == src)
         return cpuPkg::FWD_WB;    // Covers load data too
      return cpuPkg::FWD_REG;
   endfunction

   // Load in ID/EX feeding the next word
   assign stall = exMemRead && ((usesA && srcA == exRd) ||
                                (usesB && srcB == exRd) ||
                                (usesStore && srcStore == exRd));

   assign memFwdOk = memRegWrite && !memRead;   // Load data not ready in EX/MEM
   assign fwdA     = pickFwd(exRs, memRd, memFwdOk, wbAddr, wbWrite);
   assign fwdB     = pickFwd(exRt, memRd, memFwdOk, wbAddr, wbWrite);
   assign fwdStore = pickFwd(exStoreReg, memRd, memFwdOk, wbAddr, wbWrite);

endmodule

`default_nettype wire

// ==== rtl/cpuMemory.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuMemory #(
   parameter int dmemAddrBits = 8
) (
   input  logic             clk,
   input  logic             reset,
   input  cpuPkg::word_t    aluOut,      // Address for LW and SW
   input  cpuPkg::word_t    storeData,
   input  cpuPkg::regAddr_t rd,
   input  logic             memRead,
   input  logic             memWrite,
   input  logic             regWrite,
   input  logic             isHalt,
   output logic             wbWrite,
   output cpuPkg::regAddr_t wbAddr,
   output cpuPkg::word_t    wbData,
   output logic             hlt
);

   cpuPkg::word_t           dmem [2**dmemAddrBits];
   cpuPkg::word_t           loadQ;     // Synchronous read data
   cpuPkg::word_t           aluQ;
   logic                    loadSel;   // Writeback takes memory data
   logic [dmemAddrBits-1:0] addr;

   assign addr = aluOut[dmemAddrBits-1:0];

   always_ff @(posedge clk) begin
      if (memWrite)
         dmem[addr] <= storeData;
      loadQ <= dmem[addr];
      aluQ  <= aluOut;
      wbAddr <= rd;
   end

   // MEM/WB controls and the halt latch
   always_ff @(posedge clk) begin
      if (reset) begin
         wbWrite <= 1'b0;
         loadSel <= 1'b0;
         hlt     <= 1'b0;
      end else begin
         wbWrite <= regWrite;
         loadSel <= memRead;
         hlt     <= hlt || isHalt;   // Rises as HLT enters writeback
      end
   end

   assign wbData = loadSel ? loadQ : aluQ;

endmodule

`default_nettype wire

// ==== rtl/cpuExecute.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuExecute (
   input  logic             clk,
   input  logic             reset,
   input  cpuPkg::opcode_t  exAluOp,
   input  logic             exImmSel,
   input  cpuPkg::word_t    exImm,
   input  cpuPkg::word_t    exDataA,
   input  cpuPkg::word_t    exDataB,
   input  cpuPkg::regAddr_t exRd,
   input  logic             exMemRead,
   input  logic             exMemWrite,
   input  logic             exRegWrite,
   input  logic             exIsBranch,
   input  cpuPkg::cond_t    exCond,
   input  cpuPkg::word_t    exTarget,
   input  logic             exIsHalt,
   input  cpuPkg::fwdSel_t  fwdA,
   input  cpuPkg::fwdSel_t  fwdB,
   input  cpuPkg::fwdSel_t  fwdStore,
   input  cpuPkg::word_t    memAluOut,    // EX/MEM result fed back
   input  cpuPkg::word_t    wbData,
   output logic             branchTaken,
   output cpuPkg::word_t    branchTarget,
   output logic             flush,
   output cpuPkg::word_t    memAluOutQ,
   output cpuPkg::word_t    memStoreData,
   output cpuPkg::regAddr_t memRd,
   output logic             memRead,
   output logic             memWrite,
   output logic             memRegWrite,
   output logic             memIsHalt
);

   cpuPkg::word_t opA;
   cpuPkg::word_t opB;
   cpuPkg::word_t aluB;       // Register or immediate
   cpuPkg::word_t storeVal;
   cpuPkg::word_t result;
   logic          zFlag;
   logic          nFlag;
   logic          condTrue;

   function automatic cpuPkg::word_t fwdMux(
      input cpuPkg::fwdSel_t sel,
      input cpuPkg::word_t   regVal,
      input cpuPkg::word_t   memVal,
      input cpuPkg::word_t   wbVal
   );
      case (sel)
         cpuPkg::FWD_MEM: return memVal;
         cpuPkg::FWD_WB:  return wbVal;
         default:         return regVal;
      endcase
   endfunction

   assign opA      = fwdMux(fwdA, exDataA, memAluOut, wbData);
   assign opB      = fwdMux(fwdB, exDataB, memAluOut, wbData);
   assign storeVal = fwdMux(fwdStore, exDataB, memAluOut, wbData);  // SW data rides on B
   assign aluB     = exImmSel ? exImm : opB;

   always_comb begin
      case (exAluOp)
         cpuPkg::OP_ADD: result = opA + aluB;
         cpuPkg::OP_SUB: result = opA - aluB;
         cpuPkg::OP_AND: result = opA & aluB;
         cpuPkg::OP_XOR: result = opA ^ aluB;
         cpuPkg::OP_SLL: result = opA << aluB[3:0];
         cpuPkg::OP_SRL: result = opA >> aluB[3:0];   // Logical
         cpuPkg::OP_LDI: result = exImm;
         default:        result = opA + exImm;        // LW and SW address
      endcase
   end

   // Flags follow ALU opcodes only
   always_ff @(posedge clk) begin
      if (reset) begin
         zFlag <= 1'b0;
         nFlag <= 1'b0;
      end else if (exRegWrite && exAluOp <= cpuPkg::OP_SRL) begin
         zFlag <= result == '0;
         nFlag <= result[15];
      end
   end

   always_comb begin
      case (exCond)
         cpuPkg::COND_NE:     condTrue = !zFlag;
         cpuPkg::COND_EQ:     condTrue = zFlag;
         cpuPkg::COND_LT:     condTrue = nFlag;
         cpuPkg::COND_ALWAYS: condTrue = 1'b1;
         default:             condTrue = 1'b0;
      endcase
   end

   assign branchTaken  = exIsBranch && condTrue;
   assign flush        = branchTaken;    // Kills IF/ID and the word in fetch
   assign branchTarget = exTarget;

   // EX/MEM
   always_ff @(posedge clk) begin
      if (reset) begin
         memRead     <= 1'b0;
         memWrite    <= 1'b0;
         memRegWrite <= 1'b0;
         memIsHalt   <= 1'b0;
      end else begin
         memRead     <= exMemRead;
         memWrite    <= exMemWrite;
         memRegWrite <= exRegWrite;
         memIsHalt   <= exIsHalt;
      end
      memAluOutQ   <= result;
      memStoreData <= storeVal;
      memRd        <= exRd;
   end

endmodule

`default_nettype wire

// ==== rtl/cpuDecode.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuDecode (
   input  logic             clk,
   input  logic             reset,
   input  cpuPkg::word_t    instrId,
   input  cpuPkg::word_t    pcId,
   input  logic             stall,
   input  logic             flush,
   input  logic             wbWrite,
   input  cpuPkg::regAddr_t wbAddr,
   input  cpuPkg::word_t    wbData,
   output logic             halting,
   output cpuPkg::regAddr_t srcA,
   output cpuPkg::regAddr_t srcB,
   output cpuPkg::regAddr_t srcStore,
   output logic             usesA,
   output logic             usesB,
   output logic             usesStore,
   output cpuPkg::opcode_t  exAluOp,
   output logic             exImmSel,
   output cpuPkg::word_t    exImm,
   output cpuPkg::word_t    exDataA,
   output cpuPkg::word_t    exDataB,     // rt value, or store data for SW
   output cpuPkg::regAddr_t exRd,
   output cpuPkg::regAddr_t exRs,
   output cpuPkg::regAddr_t exRt,
   output cpuPkg::regAddr_t exStoreReg,
   output logic             exMemRead,
   output logic             exMemWrite,
   output logic             exRegWrite,
   output logic             exIsBranch,
   output cpuPkg::cond_t    exCond,
   output cpuPkg::word_t    exTarget,
   output logic             exIsHalt
);

   cpuPkg::word_t    regs [16];
   cpuPkg::opcode_t  op;
   cpuPkg::regAddr_t rd;
   cpuPkg::regAddr_t rs;
   cpuPkg::regAddr_t rt;
   cpuPkg::regAddr_t readB;     // Second read port address
   cpuPkg::word_t    dataA;
   cpuPkg::word_t    dataB;
   cpuPkg::word_t    imm;
   logic             isAlu;
   logic             immSel;
   logic             memRead;
   logic             memWrite;
   logic             regWrite;

   assign op = instrId[15:12];
   assign rd = instrId[11:8];
   assign rs = instrId[7:4];
   assign rt = instrId[3:0];

   assign isAlu    = op <= cpuPkg::OP_SRL;    // ADD through SRL
   assign memRead  = op == cpuPkg::OP_LW;
   assign memWrite = op == cpuPkg::OP_SW;
   assign regWrite = isAlu || memRead || op == cpuPkg::OP_LDI;
   assign immSel   = op inside {cpuPkg::OP_SLL, cpuPkg::OP_SRL, cpuPkg::OP_LDI,
                                cpuPkg::OP_LW, cpuPkg::OP_SW};
   assign halting  = op == cpuPkg::OP_HLT && !flush;

   // Sources as seen by the hazard unit
   assign srcA      = rs;
   assign srcB      = rt;
   assign srcStore  = rd;                       // SW stores rd
   assign usesA     = isAlu || memRead || memWrite;
   assign usesB     = op <= cpuPkg::OP_XOR;     // Register-register forms only
   assign usesStore = memWrite;

   always_comb begin
      case (op)
         cpuPkg::OP_LDI:              imm = {{8{instrId[7]}}, instrId[7:0]};
         cpuPkg::OP_LW, cpuPkg::OP_SW: imm = {{12{instrId[3]}}, instrId[3:0]};
         default:                     imm = {12'd0, instrId[3:0]};   // Shift amount
      endcase
   end

   // Write-through so a same-cycle writeback is seen
   assign readB = memWrite ? rd : rt;
   assign dataA = (wbWrite && wbAddr == rs) ? wbData : regs[rs];
   assign dataB = (wbWrite && wbAddr == readB) ? wbData : regs[readB];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 16; i++)
            regs[i] <= '0;
      end else if (wbWrite) begin
         regs[wbAddr] <= wbData;
      end
   end

   // ID/EX controls, bubble on stall or flush
   always_ff @(posedge clk) begin
      if (reset || stall || flush) begin
         exMemRead  <= 1'b0;
         exMemWrite <= 1'b0;
         exRegWrite <= 1'b0;
         exIsBranch <= 1'b0;
         exIsHalt   <= 1'b0;
      end else begin
         exMemRead  <= memRead;
         exMemWrite <= memWrite;
         exRegWrite <= regWrite;
         exIsBranch <= op == cpuPkg::OP_B;
         exIsHalt   <= op == cpuPkg::OP_HLT;
      end
   end

   // ID/EX payload
   always_ff @(posedge clk) begin
      exAluOp    <= op;
      exImmSel   <= immSel;
      exImm      <= imm;
      exDataA    <= dataA;
      exDataB    <= dataB;
      exRd       <= rd;
      exRs       <= rs;
      exRt       <= rt;
      exStoreReg <= rd;
      exCond     <= instrId[11:9];
      exTarget   <= pcId + 16'd1 + {{7{instrId[8]}}, instrId[8:0]};  // Signed word offset
   end

endmodule

`default_nettype wire

// ==== rtl/cpuFetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuFetch #(
   parameter int imemAddrBits = 8
) (
   input  logic          clk,
   input  logic          reset,
   input  logic          imemWrite,     // Program load strobe
   input  cpuPkg::word_t imemAddr,
   input  cpuPkg::word_t imemData,
   input  logic          stall,         // Load-use hold
   input  logic          flush,         // Taken branch in execute
   input  logic          halting,       // HLT sitting in IF/ID
   input  logic          branchTaken,
   input  cpuPkg::word_t branchTarget,
   output cpuPkg::word_t pc,
   output cpuPkg::word_t instrId,
   output cpuPkg::word_t pcId
);

   cpuPkg::word_t imem [2**imemAddrBits];
   cpuPkg::word_t instrIf;   // Word at the current PC
   logic          frozen;    // Halt committed, fetch stays stopped

   // Load port, one word per strobe
   always_ff @(posedge clk) begin
      if (imemWrite)
         imem[imemAddr[imemAddrBits-1:0]] <= imemData;
   end

   assign instrIf = imem[pc[imemAddrBits-1:0]];

   always_ff @(posedge clk) begin
      if (reset) begin
         pc     <= '0;
         frozen <= 1'b0;
      end else begin
         if (branchTaken)
            pc <= branchTarget;                    // Redirect wins over stall
         else if (!(stall || halting || frozen))
            pc <= pc + 16'd1;
         if (halting)
            frozen <= 1'b1;
      end
   end

   // IF/ID
   always_ff @(posedge clk) begin
      if (reset || flush || halting || frozen)
         instrId <= cpuPkg::NOP_INSTR;
      else if (!stall)
         instrId <= instrIf;
      if (!stall)
         pcId <= pc;   // Only used for branch targets
   end

endmodule

`default_nettype wire

// ==== rtl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

   typedef logic [15:0] word_t;     // Data, instruction and PC word
   typedef logic [3:0]  regAddr_t;  // One of sixteen registers
   typedef logic [3:0]  opcode_t;   // Bits 15 to 12
   typedef logic [2:0]  cond_t;     // Branch condition, bits 11 to 9
   typedef logic [1:0]  fwdSel_t;   // Operand source in execute

   localparam opcode_t OP_ADD = 4'd0;
   localparam opcode_t OP_SUB = 4'd1;
   localparam opcode_t OP_AND = 4'd2;
   localparam opcode_t OP_XOR = 4'd3;
   localparam opcode_t OP_SLL = 4'd4;
   localparam opcode_t OP_SRL = 4'd5;   // Last flag-setting opcode
   localparam opcode_t OP_LDI = 4'd6;
   localparam opcode_t OP_LW  = 4'd7;
   localparam opcode_t OP_SW  = 4'd8;
   localparam opcode_t OP_B   = 4'd9;
   localparam opcode_t OP_HLT = 4'd15;

   localparam cond_t COND_NE     = 3'd0;  // Z clear
   localparam cond_t COND_EQ     = 3'd1;  // Z set
   localparam cond_t COND_LT     = 3'd2;  // N set
   localparam cond_t COND_ALWAYS = 3'd3;

   localparam fwdSel_t FWD_REG = 2'd0;  // Value carried in ID/EX
   localparam fwdSel_t FWD_MEM = 2'd1;  // EX/MEM ALU result
   localparam fwdSel_t FWD_WB  = 2'd2;  // Writeback data

   // Opcode 14 is unused, every other bit set
   localparam word_t NOP_INSTR = 16'hEFFF;

endpackage

`default_nettype wire
